//--- common/aes_settings.svh
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

// block and key are the same width for AES-128
`define AES_BLOCK_BITS   128
`define AES_NUM_ROUNDS   10
`define AES_ROUND_BITS   4

// low byte of x^8 + x^4 + x^3 + x + 1
`define AES_REDUCE_POLY  8'h1b
`define AES_RCON_FIRST   8'h01
`define AES_AFFINE_CONST 8'h63

`endif

//--- common/aes_pkg.sv
`include "aes_settings.svh"

package aes_pkg;

    typedef logic [7:0]  aes_byte_t;
    typedef logic [31:0] aes_word_t;

    // col[0] sits in the top bits, row 0 is the top byte of a column
    typedef union packed {
        logic [`AES_BLOCK_BITS-1:0] flat;
        aes_word_t [0:3]            col;
    } aes_state_u;

    function automatic aes_byte_t xtime(input aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? `AES_REDUCE_POLY : 8'h00);
    endfunction

    // shift-and-add multiply in GF(2^8)
    function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
        aes_byte_t acc;
        aes_byte_t sh;
        acc = 8'h00;
        sh  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            sh = xtime(sh);
        end
        return acc;
    endfunction

    // b^254 by repeated squaring, zero stays zero
    function automatic aes_byte_t gf_inv(input aes_byte_t b);
        aes_byte_t sq;
        aes_byte_t acc;
        sq  = b;
        acc = 8'h01;
        for (int i = 1; i < 8; i++) begin
            sq  = gf_mul(sq, sq);
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

endpackage

//--- aes/aes_sbox.sv
`timescale 1ns/1ns
`include "aes_settings.svh"

module aes_sbox (
    input  aes_pkg::aes_byte_t in_byte,
    output aes_pkg::aes_byte_t out_byte
);
    import aes_pkg::*;

    aes_byte_t inv;
    aes_byte_t aff;

    // multiplicative inverse first
    assign inv = gf_inv(in_byte);

    // affine map over GF(2)
    // bit i takes bits i, i+4, i+5, i+6, i+7 of the inverse
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            aff[i] = inv[i]
                   ^ inv[(i + 4) % 8]
                   ^ inv[(i + 5) % 8]
                   ^ inv[(i + 6) % 8]
                   ^ inv[(i + 7) % 8];
        end
    end

    assign out_byte = aff ^ `AES_AFFINE_CONST;

endmodule

//--- aes/aes_round.sv
`timescale 1ns/1ns
`include "aes_settings.svh"

module aes_round (
    input  aes_pkg::aes_state_u        state_in,
    input  logic [`AES_BLOCK_BITS-1:0] round_key,
    input  logic                       last_round,
    output aes_pkg::aes_state_u        round_out
);
    import aes_pkg::*;

    // sbox outputs indexed [column][row]
    aes_byte_t  sb [4][4];
    aes_state_u shifted;
    aes_state_u mixed;

    for (genvar c = 0; c < 4; c++) begin : g_col
        for (genvar r = 0; r < 4; r++) begin : g_row
            aes_sbox u_sbox (
                .in_byte  (state_in.col[c][31-8*r -: 8]),
                .out_byte (sb[c][r])
            );
        end
    end

    // row r rotates left by r columns
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shifted.col[c][31-8*r -: 8] = sb[(c + r) % 4][r];
            end
        end
    end

    // circulant {2,3,1,1}, 3x is xtime(x) ^ x
    always_comb begin : mix_cols
        aes_byte_t a [4];
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                a[r] = shifted.col[c][31-8*r -: 8];
            end
            for (int r = 0; r < 4; r++) begin
                mixed.col[c][31-8*r -: 8] = xtime(a[r])
                                          ^ xtime(a[(r + 1) % 4])
                                          ^ a[(r + 1) % 4]
                                          ^ a[(r + 2) % 4]
                                          ^ a[(r + 3) % 4];
            end
        end
    end

    // final round skips the column mix
    assign round_out.flat = (last_round ? shifted.flat : mixed.flat) ^ round_key;

endmodule

//--- aes/aes_key_schedule.sv
`timescale 1ns/1ns
`include "aes_settings.svh"

module aes_key_schedule (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load,
    input  logic                       step,
    input  logic [`AES_BLOCK_BITS-1:0] key,
    output logic [`AES_BLOCK_BITS-1:0] round_key
);
    import aes_pkg::*;

    logic [`AES_BLOCK_BITS-1:0] key_q;
    aes_byte_t                  rcon_q;

    aes_word_t w0;
    aes_word_t w1;
    aes_word_t w2;
    aes_word_t w3;
    aes_word_t rot_w;
    aes_word_t temp_w;
    aes_word_t n0;
    aes_word_t n1;
    aes_word_t n2;
    aes_word_t n3;
    aes_byte_t sub_b [4];

    assign {w0, w1, w2, w3} = key_q;

    // RotWord of the last word
    assign rot_w = {w3[23:0], w3[31:24]};

    // SubWord
    for (genvar i = 0; i < 4; i++) begin : g_subword
        aes_sbox u_sbox (
            .in_byte  (rot_w[31-8*i -: 8]),
            .out_byte (sub_b[i])
        );
    end

    assign temp_w = {sub_b[0], sub_b[1], sub_b[2], sub_b[3]} ^ {rcon_q, 24'h000000};

    assign n0 = w0 ^ temp_w;
    assign n1 = w1 ^ n0;
    assign n2 = w2 ^ n1;
    assign n3 = w3 ^ n2;

    // next round key, consumed by the round at the next step
    assign round_key = {n0, n1, n2, n3};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rcon_q <= `AES_RCON_FIRST;
        end else if (load) begin
            rcon_q <= `AES_RCON_FIRST;
        end else if (step) begin
            rcon_q <= xtime(rcon_q);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            key_q <= key;
        end else if (step) begin
            key_q <= round_key;
        end
    end

endmodule

//--- aes/aes_core.sv
`timescale 1ns/1ns
`include "aes_settings.svh"

module aes_core (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic [`AES_BLOCK_BITS-1:0] key,
    input  logic [`AES_BLOCK_BITS-1:0] plaintext,
    output logic                       busy,
    output logic                       done,
    output logic [`AES_BLOCK_BITS-1:0] ciphertext
);
    import aes_pkg::*;

    aes_state_u                 state_q;
    aes_state_u                 round_out;
    logic [`AES_ROUND_BITS-1:0] round_q;
    logic [`AES_BLOCK_BITS-1:0] round_key;
    logic                       load;
    logic                       step;
    logic                       last_round;

    // starts during a run are dropped
    assign load       = start && !busy;
    assign step       = busy;
    assign last_round = (round_q == `AES_ROUND_BITS'(`AES_NUM_ROUNDS));

    aes_key_schedule u_key_schedule (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .step      (step),
        .key       (key),
        .round_key (round_key)
    );

    aes_round u_round (
        .state_in   (state_q),
        .round_key  (round_key),
        .last_round (last_round),
        .round_out  (round_out)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            round_q <= '0;
        end else begin
            done <= 1'b0;
            if (load) begin
                busy    <= 1'b1;
                round_q <= `AES_ROUND_BITS'(1);
            end else if (busy) begin
                if (last_round) begin
                    busy    <= 1'b0;
                    done    <= 1'b1;
                    round_q <= '0;
                end else begin
                    round_q <= round_q + `AES_ROUND_BITS'(1);
                end
            end
        end
    end

    // initial key addition on load and one round per edge after it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q.flat <= '0;
        end else if (load) begin
            state_q.flat <= plaintext ^ key;
        end else if (step) begin
            state_q <= round_out;
        end
    end

    // state is frozen once the last round lands
    assign ciphertext = state_q.flat;

endmodule

//--- bench/tb_aes_core.sv
`timescale 1ns/1ns
`include "aes_settings.svh"

module tb_aes_core;

    localparam int RUN_TIMEOUT = 20;

    // FIPS-197 appendix C.1
    localparam logic [`AES_BLOCK_BITS-1:0] KEY_C1 = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [`AES_BLOCK_BITS-1:0] PT_C1  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [`AES_BLOCK_BITS-1:0] CT_C1  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    // FIPS-197 appendix B
    localparam logic [`AES_BLOCK_BITS-1:0] KEY_B  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam logic [`AES_BLOCK_BITS-1:0] PT_B   = 128'h3243f6a8885a308d313198a2e0370734;
    localparam logic [`AES_BLOCK_BITS-1:0] CT_B   = 128'h3925841d02dc09fbdc118597196a0b32;

    logic                       clk;
    logic                       rst_n;
    logic                       start;
    logic [`AES_BLOCK_BITS-1:0] key;
    logic [`AES_BLOCK_BITS-1:0] plaintext;
    logic                       busy;
    logic                       done;
    logic [`AES_BLOCK_BITS-1:0] ciphertext;

    int errors;
    int tests_run;
    int tests_failed;
    bit timed_out;

    aes_core u_aes_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .key        (key),
        .plaintext  (plaintext),
        .busy       (busy),
        .done       (done),
        .ciphertext (ciphertext)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // done is a single-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            $display("[ERROR] %0t done expected 0 got 1 (second cycle high)", $time);
            errors++;
        end

    done_idle: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
        else begin
            $display("[ERROR] %0t busy expected 0 got 1 while done high", $time);
            errors++;
        end

    start_taken: assert property (@(posedge clk) disable iff (!rst_n)
                                  (start && !busy) |=> busy)
        else begin
            $display("[ERROR] %0t busy expected 1 got 0 after accepted start", $time);
            errors++;
        end

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (act === exp)
            else begin
                $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
                errors++;
            end
    endtask

    // pulse start, then count edges until done; optionally pulse start again mid-run
    task automatic encrypt_block(input logic [127:0] k, input logic [127:0] p,
                                 input int intrude_at, output int edges,
                                 output int busy_drops);
        bit seen;
        @(negedge clk);
        key       = k;
        plaintext = p;
        start     = 1'b1;
        @(negedge clk);
        start      = 1'b0;
        edges      = 0;
        busy_drops = 0;
        seen       = 1'b0;
        while (!seen && edges < RUN_TIMEOUT) begin
            @(negedge clk);
            edges++;
            if (edges == intrude_at) begin
                start     = 1'b1;
                key       = ~k;
                plaintext = ~p;
            end else begin
                start = 1'b0;
            end
            if (done) begin
                seen = 1'b1;
            end else if (!busy) begin
                busy_drops++;
            end
        end
        start = 1'b0;
        if (!seen) begin
            $display("timeout: done did not rise within %0d cycles after start", RUN_TIMEOUT);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %-18s ok", name);
        end else begin
            tests_failed++;
            $display("test %-18s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int mark;
        int edges;
        int drops;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        rst_n        = 1'b0;
        start        = 1'b0;
        key          = '0;
        plaintext    = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        mark = errors;
        check_value("busy", 128'(1'b0), 128'(busy));
        check_value("done", 128'(1'b0), 128'(done));
        check_value("ciphertext", '0, ciphertext);
        report_test("reset_state", mark);

        mark = errors;
        encrypt_block(KEY_C1, PT_C1, 0, edges, drops);
        check_value("ciphertext", CT_C1, ciphertext);
        report_test("fips_c1_vector", mark);

        mark = errors;
        encrypt_block(KEY_B, PT_B, 0, edges, drops);
        check_value("ciphertext", CT_B, ciphertext);
        report_test("fips_b_vector", mark);

        mark = errors;
        encrypt_block(KEY_C1, PT_C1, 0, edges, drops);
        check_value("done_edges", 128'(10), 128'(edges));
        check_value("busy_drops", 128'(0), 128'(drops));
        check_value("busy", 128'(1'b0), 128'(busy));
        @(negedge clk);
        check_value("done", 128'(1'b0), 128'(done));
        check_value("busy", 128'(1'b0), 128'(busy));
        report_test("done_timing", mark);

        // second start lands on the fifth round edge
        mark = errors;
        encrypt_block(KEY_C1, PT_C1, 4, edges, drops);
        check_value("done_edges", 128'(10), 128'(edges));
        check_value("busy_drops", 128'(0), 128'(drops));
        check_value("ciphertext", CT_C1, ciphertext);
        report_test("start_while_busy", mark);

        mark = errors;
        for (int i = 0; i < 5; i++) begin
            key       = KEY_B ^ 128'(i + 1);
            plaintext = PT_B ^ 128'(i + 7);
            @(negedge clk);
            check_value("ciphertext", CT_C1, ciphertext);
            check_value("done", 128'(1'b0), 128'(done));
        end
        report_test("result_held", mark);

        $display("tests run %0d, tests failed %0d, errors %0d, timeout %0d",
                 tests_run, tests_failed, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+common
common/aes_pkg.sv
aes/aes_sbox.sv
aes/aes_round.sv
aes/aes_key_schedule.sv
aes/aes_core.sv
bench/tb_aes_core.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs tb_aes_core with Verilator, output goes to sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_aes_core -Mdir obj_dir -f list.f \
    && ./obj_dir/Vtb_aes_core 2>&1 | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }

grep -q "TEST FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0
